// ==== hisBuilderTop.f ====
+incdir+src
src/hisPkg.sv
src/hisSequencer.sv
src/hisBinMemory.sv
src/hisPeakTracker.sv
src/hisWindowCalc.sv
src/hisBuilderTop.sv
tests/hisBuilder_asserts.sv
tests/hisBuilderTb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the histogram builder testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module hisBuilderTb \
    -f hisBuilderTop.f \
    -o hisBuilderSim

# exit status is the simulation result
./obj_dir/hisBuilderSim

// ==== src/hisBinMemory.sv ====
`default_nettype none

`include "his_macros.svh"

module hisBinMemory (
    input  wire logic             clk,
    input  wire logic             combin_res,
    input  wire logic             accept,
    input  wire hisPkg::pixelIdxT curPixel,
    input  wire hisPkg::binAddrT  sampleBin,
    input  wire logic             clearAll,
    output logic                  updValid,
    output hisPkg::pixelIdxT      updPixel,
    output hisPkg::binAddrT       updBin,
    output hisPkg::binCountT      updCount
);

    import hisPkg::*;

    // one row of 2**bin bits entries per pixel
    localparam int ADDR_BITS = PIX_BITS + `HIS_BIN_BITS;
    localparam int DEPTH = 1 << ADDR_BITS;

    binCountT             countMem [DEPTH];
    logic [DEPTH-1:0]     entryValid;
    logic [ADDR_BITS-1:0] entryAddr;
    binCountT             oldCount;
    binCountT             newCount;

    // pixel selects the histogram, bin selects the entry
    assign entryAddr = {curPixel, sampleBin};

    // cleared entry reads as zero
    assign oldCount = entryValid[entryAddr] ? countMem[entryAddr] : '0;
    assign newCount = oldCount + binCountT'(1);

    // valid bits and update strobe
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            entryValid <= '0;
            updValid <= 1'b0;
        end else begin
            // whole memory cleared in one cycle
            if (clearAll) begin
                entryValid <= '0;
            end else if (accept) begin
                entryValid[entryAddr] <= 1'b1;
            end
            updValid <= accept;
        end
    end

    // count storage, written at the accepting edge
    always_ff @(posedge clk) begin
        if (accept) begin
            countMem[entryAddr] <= newCount;
        end
    end

    // updated count for the peak tracker
    // visible one cycle after acceptance
    always_ff @(posedge clk) begin
        if (accept) begin
            updPixel <= curPixel;
            updBin <= sampleBin;
            updCount <= newCount;
        end
    end

endmodule

`default_nettype wire

// ==== src/hisBuilderTop.sv ====
`default_nettype none

module hisBuilderTop (
    input  wire logic            clk,
    input  wire logic            combin_res,
    input  wire logic            sampleValid,
    input  wire hisPkg::binAddrT sampleBin,
    output logic                 sampleReady,
    output logic                 resultValid,
    output hisPkg::pixelIdxT     resultPixel,
    output hisPkg::binAddrT      peakBin,
    output hisPkg::binCountT     peakCount,
    output hisPkg::fineCodeT     windowLow,
    output hisPkg::fineCodeT     windowHigh,
    output logic                 frameParity
);

    import hisPkg::*;

    // sequencer to memory
    logic     accept;
    pixelIdxT curPixel;
    // memory to tracker
    logic     updValid;
    pixelIdxT updPixel;
    binAddrT  updBin;
    binCountT updCount;
    // frame control
    logic     frameDone;
    logic     streamDone;
    logic     clearAll;
    // tracker to window calculator
    logic     peakReq;
    binAddrT  reqBin;

    hisSequencer hisSequencer_i (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleValid(sampleValid),
        .sampleReady(sampleReady),
        .accept     (accept),
        .curPixel   (curPixel),
        .frameDone  (frameDone),
        .streamDone (streamDone),
        .clearAll   (clearAll),
        .frameParity(frameParity)
    );

    hisBinMemory hisBinMemory_i (
        .clk       (clk),
        .combin_res(combin_res),
        .accept    (accept),
        .curPixel  (curPixel),
        .sampleBin (sampleBin),
        .clearAll  (clearAll),
        .updValid  (updValid),
        .updPixel  (updPixel),
        .updBin    (updBin),
        .updCount  (updCount)
    );

    hisPeakTracker hisPeakTracker_i (
        .clk        (clk),
        .combin_res (combin_res),
        .updValid   (updValid),
        .updPixel   (updPixel),
        .updBin     (updBin),
        .updCount   (updCount),
        .frameDone  (frameDone),
        .clearAll   (clearAll),
        .peakReq    (peakReq),
        .reqBin     (reqBin),
        .resultValid(resultValid),
        .resultPixel(resultPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .streamDone (streamDone)
    );

    hisWindowCalc hisWindowCalc_i (
        .clk       (clk),
        .combin_res(combin_res),
        .peakReq   (peakReq),
        .reqBin    (reqBin),
        .windowLow (windowLow),
        .windowHigh(windowHigh)
    );

endmodule

`default_nettype wire

// ==== src/hisPeakTracker.sv ====
`default_nettype none

`include "his_macros.svh"

module hisPeakTracker (
    input  wire logic             clk,
    input  wire logic             combin_res,
    input  wire logic             updValid,
    input  wire hisPkg::pixelIdxT updPixel,
    input  wire hisPkg::binAddrT  updBin,
    input  wire hisPkg::binCountT updCount,
    input  wire logic             frameDone,
    input  wire logic             clearAll,
    output logic                  peakReq,
    output hisPkg::binAddrT       reqBin,
    output logic                  resultValid,
    output hisPkg::pixelIdxT      resultPixel,
    output hisPkg::binAddrT       peakBin,
    output hisPkg::binCountT      peakCount,
    output logic                  streamDone
);

    import hisPkg::*;

    // running maximum and its bin per pixel
    binCountT maxCount [`HIS_PIXELS];
    binAddrT  maxBin [`HIS_PIXELS];

    logic     walking;
    pixelIdxT walkIdx;
    logic     lastWalk;

    assign lastWalk = (walkIdx == pixelIdxT'(`HIS_PIXELS - 1));

    // peak bin goes to the window calculator while walking
    assign peakReq = walking;
    assign reqBin = maxBin[walkIdx];

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            for (int i = 0; i < `HIS_PIXELS; i++) begin
                maxCount[i] <= '0;
                maxBin[i] <= '0;
            end
            walking <= 1'b0;
            walkIdx <= '0;
            resultValid <= 1'b0;
            streamDone <= 1'b0;
        end else begin
            // strictly greater only
            // on a tie the earlier bin keeps the peak
            if (clearAll) begin
                for (int i = 0; i < `HIS_PIXELS; i++) begin
                    maxCount[i] <= '0;
                    maxBin[i] <= '0;
                end
            end else if (updValid && (updCount > maxCount[updPixel])) begin
                maxCount[updPixel] <= updCount;
                maxBin[updPixel] <= updBin;
            end

            // walk pixels in ascending order after frame end
            // last update lands on the same edge the walk starts
            if (frameDone) begin
                walking <= 1'b1;
                walkIdx <= '0;
            end else if (walking) begin
                if (lastWalk) begin
                    walking <= 1'b0;
                    walkIdx <= '0;
                end else begin
                    walkIdx <= walkIdx + 1'b1;
                end
            end

            // result one cycle behind the request, in step with the window
            resultValid <= walking;
            streamDone <= walking & lastWalk;
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (walking) begin
            resultPixel <= walkIdx;
            peakBin <= maxBin[walkIdx];
            peakCount <= maxCount[walkIdx];
        end
    end

endmodule

`default_nettype wire

// ==== src/hisPkg.sv ====
`default_nettype none

`include "his_macros.svh"

package hisPkg;

    // pixel index width
    // kept at least one bit for a single-pixel build
    localparam int PIX_BITS = (`HIS_PIXELS > 1) ? $clog2(`HIS_PIXELS) : 1;

    // coarse bin code as delivered by the front end
    typedef logic [`HIS_BIN_BITS-1:0] binAddrT;

    // one histogram count
    typedef logic [`HIS_COUNT_BITS-1:0] binCountT;

    // pixel index inside the memory
    typedef logic [PIX_BITS-1:0] pixelIdxT;

    // fine-window bound
    typedef logic [`HIS_FINE_BITS-1:0] fineCodeT;

endpackage

`default_nettype wire

// ==== src/hisSequencer.sv ====
`default_nettype none

`include "his_macros.svh"

module hisSequencer (
    input  wire logic        clk,
    input  wire logic        combin_res,
    input  wire logic        sampleValid,
    output logic             sampleReady,
    output logic             accept,
    output hisPkg::pixelIdxT curPixel,
    output logic             frameDone,
    input  wire logic        streamDone,
    output logic             clearAll,
    output logic             frameParity
);

    import hisPkg::*;

    // counter widths hold the terminal value
    localparam int SAMPLE_BITS = $clog2(`HIS_SAMPLES_PER_PIXEL + 1);
    localparam int ACQ_BITS = $clog2(`HIS_ACQ_NUM + 1);

    logic [SAMPLE_BITS-1:0] sampleCnt;
    logic [ACQ_BITS-1:0]    acqCnt;
    logic                   lastSample;
    logic                   lastPixel;
    logic                   lastAcq;
    logic                   lastOfFrame;

    // valid/ready handshake
    assign accept = sampleValid & sampleReady;

    // terminal counts of the nested counters
    assign lastSample = (sampleCnt == SAMPLE_BITS'(`HIS_SAMPLES_PER_PIXEL - 1));
    assign lastPixel = (curPixel == pixelIdxT'(`HIS_PIXELS - 1));
    assign lastAcq = (acqCnt == ACQ_BITS'(`HIS_ACQ_NUM - 1));
    // last sample of last pixel in last acquisition
    assign lastOfFrame = lastSample & lastPixel & lastAcq;

    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            sampleCnt <= '0;
            curPixel <= '0;
            acqCnt <= '0;
            sampleReady <= 1'b1;
            frameDone <= 1'b0;
            clearAll <= 1'b0;
            frameParity <= 1'b0;
        end else begin
            // single-cycle pulses
            frameDone <= accept & lastOfFrame;
            clearAll <= 1'b0;

            // sample count inside one pixel visit
            if (accept) begin
                if (lastSample) begin
                    sampleCnt <= '0;
                    // next pixel, wraps into next acquisition
                    if (lastPixel) begin
                        curPixel <= '0;
                        if (lastAcq) begin
                            acqCnt <= '0;
                        end else begin
                            acqCnt <= acqCnt + 1'b1;
                        end
                    end else begin
                        curPixel <= curPixel + 1'b1;
                    end
                end else begin
                    sampleCnt <= sampleCnt + 1'b1;
                end
            end

            // input closed from last accepted sample until the clear is done
            if (accept && lastOfFrame) begin
                sampleReady <= 1'b0;
            end else if (clearAll) begin
                sampleReady <= 1'b1;
            end

            // streamDone comes with the last result
            // clear and parity flip on the following cycle
            if (streamDone && !sampleReady) begin
                clearAll <= 1'b1;
                frameParity <= ~frameParity;
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/hisWindowCalc.sv ====
`default_nettype none

`include "his_macros.svh"

module hisWindowCalc (
    input  wire logic            clk,
    input  wire logic            combin_res,
    input  wire logic            peakReq,
    input  wire hisPkg::binAddrT reqBin,
    output hisPkg::fineCodeT     windowLow,
    output hisPkg::fineCodeT     windowHigh
);

    import hisPkg::*;

    // coarse to fine scale, 16 here
    localparam int SHIFT = `HIS_FINE_BITS - `HIS_BIN_BITS;
    // half window is half a coarse bin in fine units
    localparam fineCodeT HALF_WIN = fineCodeT'(1 << (SHIFT - 1));
    localparam fineCodeT FULL_WIN = HALF_WIN << 1;
    localparam fineCodeT FINE_MAX = '1;

    fineCodeT scaled;
    fineCodeT lowNext;
    fineCodeT highNext;

    assign scaled = fineCodeT'(reqBin) << SHIFT;

    // clamp so the window stays inside the fine range
    always_comb begin
        if (scaled <= HALF_WIN) begin
            // pinned to the bottom
            lowNext = '0;
            highNext = FULL_WIN;
        end else if (scaled >= FINE_MAX - HALF_WIN) begin
            // pinned to the top
            lowNext = FINE_MAX - FULL_WIN;
            highNext = FINE_MAX;
        end else begin
            lowNext = scaled - HALF_WIN;
            highNext = scaled + HALF_WIN;
        end
    end

    // window held between requests
    always_ff @(posedge clk or negedge combin_res) begin
        if (!combin_res) begin
            windowLow <= '0;
            windowHigh <= FULL_WIN;
        end else if (peakReq) begin
            windowLow <= lowNext;
            windowHigh <= highNext;
        end
    end

endmodule

`default_nettype wire

// ==== src/his_macros.svh ====
`ifndef HIS_MACROS_SVH
`define HIS_MACROS_SVH

// coarse time-bin code width, 16 bins per histogram
`define HIS_BIN_BITS 4

// fine code width for window bounds
`define HIS_FINE_BITS 8

// pixels sharing one bin-count memory
`define HIS_PIXELS 4

// samples taken on each pixel visit
`define HIS_SAMPLES_PER_PIXEL 4

// acquisitions in one frame
`define HIS_ACQ_NUM 3

// bin count width
// frame max is samples per pixel times acquisitions, 12 here
`define HIS_COUNT_BITS 8

`endif

// ==== tests/hisBuilderTb.sv ====
`default_nettype none

`include "his_macros.svh"

module hisBuilderTb;

    import hisPkg::*;

    localparam int PIX = `HIS_PIXELS;
    localparam int SPP = `HIS_SAMPLES_PER_PIXEL;
    localparam int BINS = 1 << `HIS_BIN_BITS;
    localparam int TOTAL = `HIS_ACQ_NUM * PIX * SPP;
    // fine units per coarse bin, window is one bin wide
    localparam int SCALE = 1 << (`HIS_FINE_BITS - `HIS_BIN_BITS);
    localparam int FINE_MAX = (1 << `HIS_FINE_BITS) - 1;
    localparam int TIMEOUT = 50;

    logic     clk;
    logic     combin_res;
    logic     sampleValid;
    binAddrT  sampleBin;
    logic     sampleReady;
    logic     resultValid;
    pixelIdxT resultPixel;
    binAddrT  peakBin;
    binCountT peakCount;
    fineCodeT windowLow;
    fineCodeT windowHigh;
    logic     frameParity;

    // one frame in acceptance order, then expected peaks per pixel
    binAddrT  frameBins [TOTAL];
    binAddrT  expBin [PIX];
    binCountT expCount [PIX];
    logic     expParity;
    integer   seed;

    hisBuilderTop hisBuilderTop_i (
        .clk        (clk),
        .combin_res (combin_res),
        .sampleValid(sampleValid),
        .sampleBin  (sampleBin),
        .sampleReady(sampleReady),
        .resultValid(resultValid),
        .resultPixel(resultPixel),
        .peakBin    (peakBin),
        .peakCount  (peakCount),
        .windowLow  (windowLow),
        .windowHigh (windowHigh),
        .frameParity(frameParity)
    );

    always #20 clk = ~clk;

    task automatic abortRun(input string reason);
        $display("%s", reason);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic binEquals(input binAddrT got, input binAddrT exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic countEquals(input binCountT got, input binCountT exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic fineEquals(input fineCodeT got, input fineCodeT exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("Error at time %0t: %s is %0d, expected %0d", $time, what, got, exp));
        end
    endtask

    task automatic pixelEquals(input pixelIdxT got, input pixelIdxT exp);
        if (got !== exp) begin
            abortRun($sformatf("Error at time %0t: resultPixel is %0d, expected %0d", $time, got, exp));
        end
    endtask

    task automatic flagEquals(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            abortRun($sformatf("Error at time %0t: %s is %b, expected %b", $time, what, got, exp));
        end
    endtask

    // running max per pixel, strictly greater replaces
    // so a tie keeps the bin that got there first
    function automatic void buildExpected();
        binCountT hist [PIX][BINS];
        int p;
        for (int q = 0; q < PIX; q++) begin
            expBin[q] = '0;
            expCount[q] = '0;
            for (int b = 0; b < BINS; b++) begin
                hist[q][b] = '0;
            end
        end
        for (int i = 0; i < TOTAL; i++) begin
            p = (i / SPP) % PIX;
            hist[p][frameBins[i]] = hist[p][frameBins[i]] + 1'b1;
            if (hist[p][frameBins[i]] > expCount[p]) begin
                expCount[p] = hist[p][frameBins[i]];
                expBin[p] = frameBins[i];
            end
        end
    endfunction

    // window bound from the clamping table
    function automatic fineCodeT windowBound(input binAddrT bin, input bit high);
        int scaled;
        int lo;
        scaled = int'(bin) * SCALE;
        if (scaled <= SCALE / 2) begin
            lo = 0;
        end else if (scaled >= FINE_MAX - SCALE / 2) begin
            lo = FINE_MAX - SCALE;
        end else begin
            lo = scaled - SCALE / 2;
        end
        return fineCodeT'(high ? lo + SCALE : lo);
    endfunction

    // called on a falling edge, returns on the falling edge after acceptance
    task automatic pushSample(input binAddrT bin);
        int waitCnt;
        waitCnt = 0;
        sampleValid = 1'b1;
        sampleBin = bin;
        while (!sampleReady) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > TIMEOUT) begin
                abortRun("timeout: sampleReady stayed low while a sample was offered");
            end
        end
        @(negedge clk);
        sampleValid = 1'b0;
    endtask

    task automatic runFrame(input bit withGaps);
        int waitCnt;
        int gap;
        buildExpected();
        for (int i = 0; i < TOTAL; i++) begin
            if (withGaps) begin
                gap = {$random(seed)} % 3;
                repeat (gap) @(negedge clk);
            end
            pushSample(frameBins[i]);
        end
        // input closed from the last accepted sample on
        flagEquals(sampleReady, 1'b0, "sampleReady after last sample");
        waitCnt = 0;
        while (!resultValid) begin
            @(negedge clk);
            flagEquals(sampleReady, 1'b0, "sampleReady before results");
            waitCnt++;
            if (waitCnt > TIMEOUT) begin
                abortRun("timeout: no result came out after the frame ended");
            end
        end
        // one result per cycle, ascending pixels
        for (int p = 0; p < PIX; p++) begin
            flagEquals(resultValid, 1'b1, "resultValid during stream");
            flagEquals(sampleReady, 1'b0, "sampleReady during stream");
            pixelEquals(resultPixel, pixelIdxT'(p));
            binEquals(peakBin, expBin[p], "peakBin");
            countEquals(peakCount, expCount[p], "peakCount");
            fineEquals(windowLow, windowBound(expBin[p], 1'b0), "windowLow");
            fineEquals(windowHigh, windowBound(expBin[p], 1'b1), "windowHigh");
            @(negedge clk);
        end
        flagEquals(resultValid, 1'b0, "resultValid after stream");
        expParity = ~expParity;
        waitCnt = 0;
        while (!sampleReady) begin
            @(negedge clk);
            waitCnt++;
            if (waitCnt > TIMEOUT) begin
                abortRun("timeout: sampleReady did not return after the results");
            end
        end
        flagEquals(frameParity, expParity, "frameParity");
    endtask

    // dominant bin base + step * pixel, last sample of each visit 8 bins away
    function automatic void fillDominant(input int base, input int step);
        int p;
        for (int i = 0; i < TOTAL; i++) begin
            p = (i / SPP) % PIX;
            frameBins[i] = binAddrT'(base + step * p + ((i % SPP == SPP - 1) ? 8 : 0));
        end
    endfunction

    task automatic afterReset();
        flagEquals(sampleReady, 1'b1, "sampleReady after reset");
        flagEquals(resultValid, 1'b0, "resultValid after reset");
        flagEquals(frameParity, 1'b0, "frameParity after reset");
    endtask

    task automatic dominantPeaks();
        fillDominant(2, 3);
        runFrame(1'b0);
    endtask

    // per pixel time order A A B B  B B A A  A B B A
    // both reach 6, B gets there first
    task automatic tiedBins();
        int k;
        int p;
        for (int i = 0; i < TOTAL; i++) begin
            p = (i / SPP) % PIX;
            k = (i / (PIX * SPP)) * SPP + i % SPP;
            frameBins[i] = binAddrT'(12'h63C >> k & 1 ? p + 4 : p);
        end
        runFrame(1'b0);
    endtask

    // peaks at 0, 5, 10 and 15
    task automatic clampedWindows();
        fillDominant(0, 5);
        runFrame(1'b0);
    endtask

    // dominant and minority bins swap between frames
    // any carry-over changes the counts
    task automatic backToBack();
        fillDominant(10, 3);
        runFrame(1'b0);
        fillDominant(2, 3);
        runFrame(1'b0);
    endtask

    task automatic randomFrame();
        for (int i = 0; i < TOTAL; i++) begin
            frameBins[i] = binAddrT'($random(seed));
        end
        runFrame(1'b1);
    endtask

    initial begin
        seed = 14467;
        clk = 1'b0;
        combin_res = 1'b0;
        sampleValid = 1'b0;
        sampleBin = '0;
        expParity = 1'b0;
        repeat (5) @(negedge clk);
        combin_res = 1'b1;
        @(negedge clk);
        afterReset();
        dominantPeaks();
        tiedBins();
        clampedWindows();
        backToBack();
        randomFrame();
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/hisBuilder_asserts.sv ====
`default_nettype none

`include "his_macros.svh"

module hisBuilderAsserts (
    input wire logic             clk,
    input wire logic             combin_res,
    input wire logic             sampleReady,
    input wire logic             resultValid,
    input wire hisPkg::pixelIdxT resultPixel,
    input wire hisPkg::fineCodeT windowLow,
    input wire hisPkg::fineCodeT windowHigh,
    input wire logic             frameParity
);

    import hisPkg::*;

    // window is one coarse bin wide in fine units
    localparam fineCodeT WIN_SPAN = fineCodeT'(1 << (`HIS_FINE_BITS - `HIS_BIN_BITS));

    // input closed while results stream
    readyDuringStream: assert property (@(posedge clk) disable iff (!combin_res)
        !(sampleReady && resultValid))
        else $error("sampleReady high during the result stream");

    // consecutive results step through the pixels
    pixelStep: assert property (@(posedge clk) disable iff (!combin_res)
        (resultValid && $past(resultValid)) |->
            (resultPixel == pixelIdxT'($past(resultPixel) + 1'b1)))
        else $error("resultPixel did not step by one");

    windowSpan: assert property (@(posedge clk) disable iff (!combin_res)
        fineCodeT'(windowHigh - windowLow) == WIN_SPAN)
        else $error("window width is not one coarse bin");

    // parity flips only with the clear, input still closed
    parityWhileClosed: assert property (@(posedge clk) disable iff (!combin_res)
        (frameParity != $past(frameParity)) |-> !sampleReady)
        else $error("frameParity changed while sampleReady was high");

endmodule

bind hisBuilderTop hisBuilderAsserts hisBuilderAsserts_i (
    .clk        (clk),
    .combin_res (combin_res),
    .sampleReady(sampleReady),
    .resultValid(resultValid),
    .resultPixel(resultPixel),
    .windowLow  (windowLow),
    .windowHigh (windowHigh),
    .frameParity(frameParity)
);

`default_nettype wire
